// ==== mem_fabric_config.svh ====
/* Memory map and width constants for the hart memory fabric.
   Include wherever an address range, RAM depth or APB width is needed. */

`ifndef MEM_FABRIC_CONFIG_SVH
`define MEM_FABRIC_CONFIG_SVH

// ==============================
// Program RAM
// ==============================
// 16 KB of word storage behind the base window
`define RAM_BASE_ADDR    32'h0001_0000
`define RAM_WORDS        4096
`define RAM_INDEX_BITS   12
// Upper 18 address bits all ones alias into RAM through the low 14 bits
`define RAM_ALIAS_TAG    18'h3FFFF

// ==============================
// Debug Module and test support
// ==============================
// Progbuf, debug ROM and flag area, reached over APB in debug mode
`define DEBUG_AREA_START 32'h0000_0200
`define DEBUG_AREA_END   32'h0000_0FFF
`define TOHOST_ADDR      32'h8000_1000
`define APB_ADDR_BITS    13

`endif

// ==== mem_fabric_pkg.sv ====
/* Shared types of the memory fabric: vector widths, port structs and FSM enums.
   Modules pull these in with a wildcard import in their header. */

`include "mem_fabric_config.svh"

package mem_fabric_pkg;

  // Plain vectors with a meaning
  typedef logic [31:0]                   word_t;
  typedef logic [31:0]                   addr_t;
  typedef logic [`RAM_INDEX_BITS-1:0]    ram_index_t;
  typedef logic [`APB_ADDR_BITS-1:0]     apb_addr_t;

  // ==============================
  // Core side
  // ==============================
  typedef struct packed {addr_t addr; logic rready;} imem_req_t;
  typedef struct packed {word_t rdata; logic rvalid;} imem_rsp_t;
  typedef struct packed {addr_t addr; logic wvalid; word_t wdata; logic rready;} dmem_req_t;
  typedef struct packed {word_t rdata; logic rvalid; logic wready;} dmem_rsp_t;

  // ==============================
  // APB toward the Debug Module
  // ==============================
  typedef struct packed {
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
  } apb_req_t;
  typedef struct packed {word_t prdata; logic pready; logic pslverr;} apb_rsp_t;

  // Internal links between router, RAM and bridge
  typedef struct packed {logic rd_en; logic wr_en; ram_index_t index; word_t wdata;} ram_port_t;
  typedef struct packed {word_t rdata; logic valid;} ram_rsp_t;
  // Bridge completions, one pulse per originating port
  typedef struct packed {word_t rdata; logic rvalid_i; logic rvalid_d; logic wready_d;} dbg_rsp_t;

  typedef enum logic [1:0] {REGION_RAM, REGION_DEBUG, REGION_NONE} region_t;
  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_ERROR} apb_state_t;

endpackage

// ==== mem_region_router.sv ====
/* Address decode for both core ports: steers requests to RAM or the debug
   bridge, merges their completions and keeps the tohost register. */

`include "mem_fabric_config.svh"

module mem_region_router import mem_fabric_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      i_debug_mode,
  input  imem_req_t i_imem,
  input  dmem_req_t i_dmem,
  output imem_rsp_t o_imem,
  output dmem_rsp_t o_dmem,
  output ram_port_t o_ram_i,
  output ram_port_t o_ram_d,
  input  ram_rsp_t  i_ram_i,
  input  ram_rsp_t  i_ram_d,
  output logic      o_dbg_fetch,
  output logic      o_dbg_read,
  output logic      o_dbg_write,
  input  dbg_rsp_t  i_dbg,
  output word_t     o_tohost
);

  // First address bit above the aliased RAM offset
  localparam int    ALIAS_LSB = `RAM_INDEX_BITS + 2;
  localparam addr_t RAM_LIMIT = addr_t'(`RAM_BASE_ADDR + `RAM_WORDS * 4);

  region_t region_i;
  region_t region_d;
  logic    ram_wr_d;
  logic    tohost_wr;
  word_t   tohost_q;

  // Debug area only exists while the hart is in debug mode
  function automatic region_t classify(input addr_t a, input logic dbg);
    region_t r;
    r = REGION_NONE;
    if (dbg && (a >= `DEBUG_AREA_START) && (a <= `DEBUG_AREA_END))
      r = REGION_DEBUG;
    else if (((a >= `RAM_BASE_ADDR) && (a < RAM_LIMIT)) || (a[31:ALIAS_LSB] == `RAM_ALIAS_TAG))
      r = REGION_RAM;
    return r;
  endfunction

  // Alias addresses use their low bits as is, base window subtracts the base
  function automatic ram_index_t word_index(input addr_t a);
    addr_t offset;
    offset = (a[31:ALIAS_LSB] == `RAM_ALIAS_TAG) ? a : a - `RAM_BASE_ADDR;
    return offset[ALIAS_LSB-1:2];
  endfunction

  assign region_i = classify(i_imem.addr, i_debug_mode);
  assign region_d = classify(i_dmem.addr, i_debug_mode);

  // ==============================
  // Request steering
  // ==============================
  assign ram_wr_d  = i_dmem.wvalid && (region_d == REGION_RAM);
  assign tohost_wr = i_dmem.wvalid && (i_dmem.addr == `TOHOST_ADDR);

  // Fetch port never writes
  assign o_ram_i = '{rd_en: i_imem.rready && (region_i == REGION_RAM), wr_en: 1'b0,
                     index: word_index(i_imem.addr), wdata: '0};
  assign o_ram_d = '{rd_en: i_dmem.rready && (region_d == REGION_RAM), wr_en: ram_wr_d,
                     index: word_index(i_dmem.addr), wdata: i_dmem.wdata};

  assign o_dbg_fetch = i_imem.rready && (region_i == REGION_DEBUG);
  assign o_dbg_read  = i_dmem.rready && (region_d == REGION_DEBUG);
  assign o_dbg_write = i_dmem.wvalid && (region_d == REGION_DEBUG);

  // ==============================
  // Response merge
  // ==============================
  // Unmapped accesses see no valid and no ready
  always_comb
  begin
    o_imem.rvalid = i_ram_i.valid || i_dbg.rvalid_i;
    o_imem.rdata  = (region_i == REGION_DEBUG) ? i_dbg.rdata :
                    (region_i == REGION_RAM)   ? i_ram_i.rdata : '0;
    o_dmem.rvalid = i_ram_d.valid || i_dbg.rvalid_d;
    // RAM and tohost writes complete in the cycle they are seen
    o_dmem.wready = ram_wr_d || tohost_wr || i_dbg.wready_d;
    o_dmem.rdata  = (region_d == REGION_DEBUG) ? i_dbg.rdata :
                    (region_d == REGION_RAM)   ? i_ram_d.rdata : '0;
  end

  // Test result word written by the program
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      tohost_q <= '0;
    else if (tohost_wr)
      tohost_q <= i_dmem.wdata;
  end

  assign o_tohost = tohost_q;

endmodule

// ==== shared_ram.sv ====
/* Single-ported program RAM shared by fetch and data ports.
   Data write beats data read beats fetch read; reads return two cycles after grant. */

`include "mem_fabric_config.svh"

module shared_ram import mem_fabric_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  ram_port_t i_fetch,
  input  ram_port_t i_data,
  output ram_rsp_t  o_fetch,
  output ram_rsp_t  o_data
);

  word_t      mem [`RAM_WORDS];
  ram_index_t rd_index;
  word_t      rd_q;

  // Grants for this cycle and the ports that own the word in rd_q
  logic gnt_i;
  logic gnt_d;
  logic gnt_i_q;
  logic gnt_d_q;
  // One read outstanding per port, held until its valid pulse
  logic busy_i;
  logic busy_d;

  logic  fetch_valid_q;
  logic  data_valid_q;
  word_t fetch_rdata_q;
  word_t data_rdata_q;

  // ==============================
  // Port arbitration
  // ==============================
  // A data read may ride along with a data write, a fetch may not
  assign gnt_d = i_data.rd_en && !busy_d;
  assign gnt_i = i_fetch.rd_en && !busy_i && !i_data.wr_en && !gnt_d;

  assign rd_index = (i_data.wr_en || gnt_d) ? i_data.index : i_fetch.index;

  // Array and shared read register
  always_ff @(posedge clk)
  begin
    if (i_data.wr_en)
      mem[i_data.index] <= i_data.wdata;
    // Write-first on a combined data write and read
    if (gnt_d || gnt_i)
      rd_q <= i_data.wr_en ? i_data.wdata : mem[rd_index];
  end

  // ==============================
  // Grant tracking and valid pulses
  // ==============================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      gnt_i_q       <= 1'b0;
      gnt_d_q       <= 1'b0;
      busy_i        <= 1'b0;
      busy_d        <= 1'b0;
      fetch_valid_q <= 1'b0;
      data_valid_q  <= 1'b0;
    end
    else
    begin
      gnt_i_q       <= gnt_i;
      gnt_d_q       <= gnt_d;
      fetch_valid_q <= gnt_i_q;
      data_valid_q  <= gnt_d_q;
      // Clear on the edge that ends the valid cycle
      if (gnt_i)
        busy_i <= 1'b1;
      else if (fetch_valid_q)
        busy_i <= 1'b0;
      if (gnt_d)
        busy_d <= 1'b1;
      else if (data_valid_q)
        busy_d <= 1'b0;
    end
  end

  // Second stage hands the word to the port recorded at grant
  always_ff @(posedge clk)
  begin
    if (gnt_i_q)
      fetch_rdata_q <= rd_q;
    if (gnt_d_q)
      data_rdata_q <= rd_q;
  end

  assign o_fetch = '{rdata: fetch_rdata_q, valid: fetch_valid_q};
  assign o_data  = '{rdata: data_rdata_q, valid: data_valid_q};

endmodule

// ==== debug_apb_master.sv ====
/* APB master toward the Debug Module for debug-area fetches and data accesses.
   Data requests win over fetches; an error drops the transfer so the core retries. */

`include "mem_fabric_config.svh"

module debug_apb_master import mem_fabric_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     i_debug_mode,
  input  logic     i_fetch_req,
  input  logic     i_read_req,
  input  logic     i_write_req,
  input  addr_t    i_fetch_addr,
  input  addr_t    i_data_addr,
  input  word_t    i_wdata,
  output apb_req_t o_apb,
  input  apb_rsp_t i_apb,
  output dbg_rsp_t o_dbg
);

  apb_state_t state_q;
  apb_state_t state_d;

  // Transfer captured on the edge that leaves idle
  apb_addr_t addr_q;
  word_t     wdata_q;
  logic      write_q;
  logic      from_data_q;

  logic data_req;
  logic start;
  logic done;

  assign data_req = i_read_req || i_write_req;
  assign start    = i_debug_mode && (state_q == ST_IDLE) && (data_req || i_fetch_req);
  // Completion needs pready, pslverr alone is not an answer
  assign done     = i_debug_mode && (state_q == ST_ACCESS) && i_apb.pready;

  // ==============================
  // State machine
  // ==============================
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (data_req || i_fetch_req)
          state_d = ST_SETUP;
      ST_SETUP:
        state_d = ST_ACCESS;
      ST_ACCESS:
        if (i_apb.pready)
          state_d = ST_IDLE;
        else if (i_apb.pslverr)
          state_d = ST_ERROR;
      // One dead cycle, the held request then starts over from idle
      ST_ERROR:
        state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= ST_IDLE;
    else if (!i_debug_mode)
      // Leaving debug mode abandons any transfer
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      write_q     <= 1'b0;
      from_data_q <= 1'b0;
    end
    else if (start)
    begin
      write_q     <= i_write_req;
      from_data_q <= data_req;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      addr_q  <= data_req ? i_data_addr[`APB_ADDR_BITS-1:0] : i_fetch_addr[`APB_ADDR_BITS-1:0];
      wdata_q <= i_wdata;
    end
  end

  // ==============================
  // APB drive and core completions
  // ==============================
  always_comb
  begin
    o_apb.paddr   = addr_q;
    o_apb.psel    = i_debug_mode && ((state_q == ST_SETUP) || (state_q == ST_ACCESS));
    o_apb.penable = i_debug_mode && (state_q == ST_ACCESS);
    o_apb.pwrite  = write_q;
    o_apb.pwdata  = wdata_q;
  end

  // Pulse goes back to the port that started the transfer
  always_comb
  begin
    o_dbg.rdata    = i_apb.prdata;
    o_dbg.rvalid_i = done && !from_data_q;
    o_dbg.rvalid_d = done && from_data_q && !write_q;
    o_dbg.wready_d = done && from_data_q && write_q;
  end

endmodule

// ==== mem_fabric_top.sv ====
/* Memory fabric of one hart: core fetch and data ports in, program RAM,
   tohost and an APB master to the Debug Module out. */

module mem_fabric_top import mem_fabric_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      i_debug_mode,
  input  imem_req_t i_imem,
  output imem_rsp_t o_imem,
  input  dmem_req_t i_dmem,
  output dmem_rsp_t o_dmem,
  output apb_req_t  o_apb,
  input  apb_rsp_t  i_apb,
  output word_t     o_tohost
);

  // Router to RAM
  ram_port_t ram_req_i;
  ram_port_t ram_req_d;
  ram_rsp_t  ram_rsp_i;
  ram_rsp_t  ram_rsp_d;

  // Router to debug bridge
  logic     dbg_fetch;
  logic     dbg_read;
  logic     dbg_write;
  dbg_rsp_t dbg_rsp;

  // ==============================
  // Decode, RAM and bridge
  // ==============================
  mem_region_router u_router (
    .clk(clk), .reset_n(reset_n), .i_debug_mode(i_debug_mode),
    .i_imem(i_imem), .i_dmem(i_dmem), .o_imem(o_imem), .o_dmem(o_dmem),
    .o_ram_i(ram_req_i), .o_ram_d(ram_req_d), .i_ram_i(ram_rsp_i), .i_ram_d(ram_rsp_d),
    .o_dbg_fetch(dbg_fetch), .o_dbg_read(dbg_read), .o_dbg_write(dbg_write),
    .i_dbg(dbg_rsp), .o_tohost(o_tohost)
  );

  shared_ram u_ram (
    .clk(clk), .reset_n(reset_n),
    .i_fetch(ram_req_i), .i_data(ram_req_d),
    .o_fetch(ram_rsp_i), .o_data(ram_rsp_d)
  );

  // Bridge takes addresses and write data straight from the core ports
  debug_apb_master u_dbg_apb (
    .clk(clk), .reset_n(reset_n), .i_debug_mode(i_debug_mode),
    .i_fetch_req(dbg_fetch), .i_read_req(dbg_read), .i_write_req(dbg_write),
    .i_fetch_addr(i_imem.addr), .i_data_addr(i_dmem.addr), .i_wdata(i_dmem.wdata),
    .o_apb(o_apb), .i_apb(i_apb), .o_dbg(dbg_rsp)
  );

endmodule

// ==== mem_fabric_assert.sv ====
/* Concurrent protocol checks on the APB master and the core response pulses.
   Attached to the fabric top level by the bind statement at the end. */

module mem_fabric_assert import mem_fabric_pkg::*; (
  input logic      clk,
  input logic      reset_n,
  input logic      i_debug_mode,
  input apb_req_t  i_apb_req,
  input apb_rsp_t  i_apb_rsp,
  input imem_rsp_t i_imem_rsp,
  input dmem_rsp_t i_dmem_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read back by the testbench for its summary
  int fail_count = 0;

  // ==============================
  // APB
  // ==============================
  // Access phase only ever follows a setup phase
  a_penable_after_psel: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(i_apb_req.penable) |-> $past(i_apb_req.psel) && i_apb_req.psel)
  else
  begin
    $error("penable rose without a preceding setup cycle");
    fail_count++;
  end

  // Transfer held steady until the slave answers
  a_apb_stable: assert property (@(posedge clk) disable iff (!reset_n)
    (i_apb_req.psel && !(i_apb_req.penable && (i_apb_rsp.pready || i_apb_rsp.pslverr)))
    |=> (!i_debug_mode || (i_apb_req.psel && i_apb_req.penable &&
         $stable(i_apb_req.paddr) && $stable(i_apb_req.pwrite) && $stable(i_apb_req.pwdata))))
  else
  begin
    $error("APB request changed while waiting for the slave");
    fail_count++;
  end

  a_no_psel_outside_debug: assert property (@(posedge clk) disable iff (!reset_n)
    !i_debug_mode |-> !i_apb_req.psel)
  else
  begin
    $error("psel raised outside debug mode");
    fail_count++;
  end

  // ==============================
  // Core responses
  // ==============================
  a_fetch_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    i_imem_rsp.rvalid |=> !i_imem_rsp.rvalid)
  else
  begin
    $error("fetch rvalid held longer than one cycle");
    fail_count++;
  end

  a_read_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    i_dmem_rsp.rvalid |=> !i_dmem_rsp.rvalid)
  else
  begin
    $error("data rvalid held longer than one cycle");
    fail_count++;
  end

  a_write_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    i_dmem_rsp.wready |=> !i_dmem_rsp.wready)
  else
  begin
    $error("data wready held longer than one cycle");
    fail_count++;
  end

endmodule

bind mem_fabric_top mem_fabric_assert u_assert (
  .clk(clk), .reset_n(reset_n), .i_debug_mode(i_debug_mode),
  .i_apb_req(o_apb), .i_apb_rsp(i_apb), .i_imem_rsp(o_imem), .i_dmem_rsp(o_dmem)
);

// ==== tb_mem_fabric.sv ====
/* Testbench for the hart memory fabric: drives both core ports, models the
   Debug Module as an APB slave and checks RAM, debug-area and tohost traffic. */

`include "mem_fabric_config.svh"

module tb_mem_fabric import mem_fabric_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES   = 10;
  localparam int N_WORDS        = 16;
  localparam int N_ALIAS        = 4;
  localparam int N_DEBUG        = 6;
  localparam int RESPONSE_LIMIT = 40;
  // Worst access incl. APB wait states, error retry and idle gap
  localparam int ACCESS_CYCLES   = 20;
  localparam int N_ACCESSES      = 3 * N_WORDS + 3 * N_ALIAS + 3 * N_DEBUG + 8;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_ACCESSES * ACCESS_CYCLES;

  logic      clk = 1'b0;
  logic      reset_n;
  logic      debug_mode;
  imem_req_t imem_req;
  imem_rsp_t imem_rsp;
  dmem_req_t dmem_req;
  dmem_rsp_t dmem_rsp;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  word_t     tohost;

  int errors = 0;
  int checks = 0;
  // Debug Module model state
  int        err_inject = 0;
  int        apb_setups = 0;
  int        apb_writes = 0;
  int        wait_left = 0;
  logic      in_access = 1'b0;
  apb_addr_t last_paddr;
  word_t     last_pwdata;

  word_t      ref_mem [ram_index_t];
  ram_index_t idx_list [N_WORDS];

  mem_fabric_top dut (
    .clk(clk), .reset_n(reset_n), .i_debug_mode(debug_mode),
    .i_imem(imem_req), .o_imem(imem_rsp), .i_dmem(dmem_req), .o_dmem(dmem_rsp),
    .o_apb(apb_req), .i_apb(apb_rsp), .o_tohost(tohost)
  );

  always #10 clk = ~clk;

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // ==============================
  // Debug Module APB slave
  // ==============================
  // Reads return ~paddr, 0 to 3 wait states, optional pslverr answers
  always @(posedge clk)
  begin
    #2;
    apb_rsp = '0;
    // Every transfer, first try or reissue, opens with one setup cycle
    if (apb_req.psel && !apb_req.penable)
      apb_setups++;
    if (apb_req.psel && apb_req.penable)
    begin
      if (!in_access)
      begin
        in_access = 1'b1;
        wait_left = $urandom % 4;
      end
      if (wait_left > 0)
        wait_left--;
      else if (err_inject > 0)
      begin
        err_inject--;
        apb_rsp.pslverr = 1'b1;
        in_access = 1'b0;
      end
      else
      begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = {19'h0, ~apb_req.paddr};
        in_access = 1'b0;
        if (apb_req.pwrite)
        begin
          apb_writes++;
          last_paddr  = apb_req.paddr;
          last_pwdata = apb_req.pwdata;
        end
      end
    end
  end

  // ==============================
  // Address helpers and checks
  // ==============================
  function automatic addr_t ram_addr(input ram_index_t idx);
    return `RAM_BASE_ADDR + {18'h0, idx, 2'b00};
  endfunction

  // Same word through the all-ones upper tag
  function automatic addr_t alias_addr(input ram_index_t idx);
    return {`RAM_ALIAS_TAG, idx, 2'b00};
  endfunction

  function automatic addr_t debug_addr();
    addr_t off;
    off = $urandom % ((`DEBUG_AREA_END - `DEBUG_AREA_START + 1) / 4);
    return `DEBUG_AREA_START + (off << 2);
  endfunction

  function automatic word_t apb_answer(input addr_t a);
    return {19'h0, ~a[`APB_ADDR_BITS-1:0]};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Sampled at the falling edge, where every output has settled
  task automatic await_response(input string kind, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && (n < RESPONSE_LIMIT))
    begin
      @(negedge clk);
      n++;
      if (kind == "fetch")
        seen = imem_rsp.rvalid;
      else if (kind == "read")
        seen = dmem_rsp.rvalid;
      else
        seen = dmem_rsp.wready;
    end
    if (!seen)
    begin
      errors++;
      $display("No %s response within %0d cycles", kind, RESPONSE_LIMIT);
    end
  endtask

  // ==============================
  // Core port accesses
  // ==============================
  task automatic data_write(input addr_t addr, input word_t data);
    bit seen;
    @(posedge clk);
    #2;
    dmem_req.addr   = addr;
    dmem_req.wdata  = data;
    dmem_req.wvalid = 1'b1;
    await_response("write", seen);
    @(posedge clk);
    #2;
    dmem_req.wvalid = 1'b0;
  endtask

  task automatic data_read(input addr_t addr, input word_t exp);
    bit seen;
    @(posedge clk);
    #2;
    dmem_req.addr   = addr;
    dmem_req.rready = 1'b1;
    await_response("read", seen);
    if (seen)
      check_word("o_dmem.rdata", dmem_rsp.rdata, exp);
    @(posedge clk);
    #2;
    dmem_req.rready = 1'b0;
  endtask

  task automatic fetch_read(input addr_t addr, input word_t exp);
    bit seen;
    @(posedge clk);
    #2;
    imem_req.addr   = addr;
    imem_req.rready = 1'b1;
    await_response("fetch", seen);
    if (seen)
      check_word("o_imem.rdata", imem_rsp.rdata, exp);
    @(posedge clk);
    #2;
    imem_req.rready = 1'b0;
  endtask

  // Both ports held on one address, nothing may answer or select APB
  task automatic expect_silence(input addr_t addr, input logic wr);
    @(posedge clk);
    #2;
    imem_req.addr   = addr;
    imem_req.rready = 1'b1;
    dmem_req.addr   = addr;
    dmem_req.wdata  = $urandom;
    dmem_req.wvalid = wr;
    dmem_req.rready = !wr;
    repeat (8)
    begin
      @(negedge clk);
      checks++;
      assert (!imem_rsp.rvalid && !dmem_rsp.rvalid && !dmem_rsp.wready && !apb_req.psel)
      else
      begin
        errors++;
        $display("Response or psel seen for unanswerable access to %h", addr);
      end
    end
    @(posedge clk);
    #2;
    imem_req.rready = 1'b0;
    dmem_req.wvalid = 1'b0;
    dmem_req.rready = 1'b0;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    ram_index_t idx;
    addr_t      a;
    addr_t      b;
    word_t      v;
    int         setups;
    void'($urandom(32'h52c1_4134));
    reset_n    = 1'b0;
    debug_mode = 1'b0;
    imem_req   = '0;
    dmem_req   = '0;
    apb_rsp    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset_n = 1'b1;
    check_word("o_tohost", tohost, '0);

    // RAM fill, then both ports read the same words at once
    for (int i = 0; i < N_WORDS; i++)
    begin
      idx_list[i] = ram_index_t'($urandom);
      v = $urandom;
      ref_mem[idx_list[i]] = v;
      data_write(ram_addr(idx_list[i]), v);
    end
    fork
      for (int i = 0; i < N_WORDS; i++)
        data_read(ram_addr(idx_list[i]), ref_mem[idx_list[i]]);
      for (int i = N_WORDS - 1; i >= 0; i--)
        fetch_read(ram_addr(idx_list[i]), ref_mem[idx_list[i]]);
    join

    for (int i = 0; i < N_ALIAS; i++)
    begin
      idx = ram_index_t'($urandom);
      v = $urandom;
      data_write(ram_addr(idx), v);
      data_read(alias_addr(idx), v);
      fetch_read(alias_addr(idx), v);
    end

    // Debug area over APB, fetch and data competing for the bridge
    @(posedge clk);
    #2;
    debug_mode = 1'b1;
    for (int i = 0; i < N_DEBUG; i++)
    begin
      a = debug_addr();
      b = debug_addr();
      fork
        fetch_read(a, apb_answer(a));
        data_read(b, apb_answer(b));
      join
      v = $urandom;
      data_write(b, v);
      check_word("paddr", word_t'(last_paddr), word_t'(b[`APB_ADDR_BITS-1:0]));
      check_word("pwdata", last_pwdata, v);
    end
    check_word("APB write count", apb_writes, N_DEBUG);

    // Refused transfers retry from the held request, so each access is set up twice
    a = debug_addr();
    setups = apb_setups;
    err_inject = 1;
    data_read(a, apb_answer(a));
    err_inject = 1;
    fetch_read(a, apb_answer(a));
    check_word("APB setup count", apb_setups - setups, 4);

    @(posedge clk);
    #2;
    debug_mode = 1'b0;
    expect_silence(debug_addr(), 1'b0);
    expect_silence(debug_addr(), 1'b1);
    expect_silence(32'h4000_0000, 1'b1);

    v = $urandom;
    data_write(`TOHOST_ADDR, v);
    check_word("o_tohost", tohost, v);

    $display("Checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut.u_assert.fail_count);
    if ((errors == 0) && (dut.u_assert.fail_count == 0))
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
mem_fabric_pkg.sv
mem_region_router.sv
shared_ram.sv
debug_apb_master.sv
mem_fabric_top.sv
mem_fabric_assert.sv
tb_mem_fabric.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the memory fabric testbench with Verilator, runs it and scans the log.
# Exits non-zero if the build, the run or the log shows a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_mem_fabric -o sim_mem_fabric
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the testbench reaches its summary
./obj_dir/sim_mem_fabric +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation finished without failure"
exit 0
